// File: logic/flush_pkg.sv
package flush_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------
  // Program counter and address width
  localparam int unsigned AddrWidth = 32;
  // Pad setting and pad counter width
  localparam int unsigned PadWidth = 32;

  // ----------------------------------------
  // Fence.t timing
  // ----------------------------------------
  // Consecutive cache-idle cycles before padding
  localparam int unsigned DrainCycles = 16;
  // Cycles the micro-architecture is held in reset
  localparam int unsigned UarchRstCycles = 16;
  // Length of the cache-init suppression tail
  localparam int unsigned CacheInitHold = 3;
  // Step from the fence.t PC to the resume address
  localparam int unsigned InstrBytes = 4;
  // Drain counter saturates at DrainCycles
  localparam int unsigned DrainCntW = $clog2(DrainCycles + 1);
  localparam int unsigned RstCntW = $clog2(UarchRstCycles);

  // ----------------------------------------
  // Feature switches
  // ----------------------------------------
  localparam bit DcacheWriteBack = 1'b1;
  localparam bit HasSupervisor = 1'b1;
  localparam bit HasHypervisor = 1'b1;
  localparam bit HasAtomics = 1'b1;
  localparam bit HasDebug = 1'b1;

  // Privilege levels in RISC-V encoding
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // Fence.t sequence states
  typedef enum logic [2:0] {
    FT_IDLE,
    FT_FLUSH_DCACHE,
    FT_DRAIN,
    FT_PAD,
    FT_RST_UARCH
  } fence_t_state_e;

endpackage

// File: logic/fence_link_if.sv
`timescale 1ns/10ps

// Fence status from the flush decoder to the fence.t sequencer
interface fence_link_if;

  // One-cycle marker of a fence.t request
  logic                           fence_t_start;
  // Commit PC plus one instruction, valid with fence_t_start
  logic [flush_pkg::AddrWidth-1:0] resume_pc;
  // Fence or fence.i data-cache flush still waiting for its ack
  logic                           fence_active;
  // Cycle in which the cache acknowledges a pending fence flush
  logic                           dcache_done;

  // Decoder owns every signal
  modport decoder_mp (
    output fence_t_start,
    output resume_pc,
    output fence_active,
    output dcache_done
  );

  // Sequencer only observes
  modport sequencer_mp (
    input fence_t_start,
    input resume_pc,
    input fence_active,
    input dcache_done
  );

endinterface

// File: logic/flush_decoder.sv
`timescale 1ns/10ps

module flush_decoder (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            v_i,
  input  logic                            mispredict_i,
  input  logic                            fence_i,
  input  logic                            fence_i_i,
  input  logic                            fence_t_i,
  input  logic                            sfence_vma_i,
  input  logic                            hfence_vvma_i,
  input  logic                            hfence_gvma_i,
  input  logic                            flush_csr_i,
  input  logic                            flush_acc_i,
  input  logic                            flush_commit_i,
  input  logic                            ex_valid_i,
  input  logic                            eret_i,
  input  logic                            set_debug_pc_i,
  input  logic                            flush_dcache_ack_i,
  input  logic [flush_pkg::AddrWidth-1:0] pc_commit_i,
  output logic                            set_pc_commit_o,
  output logic                            flush_if_o,
  output logic                            flush_unissued_instr_o,
  output logic                            flush_id_o,
  output logic                            flush_ex_o,
  output logic                            flush_bp_o,
  output logic                            flush_icache_o,
  output logic                            flush_tlb_o,
  output logic                            flush_tlb_vvma_o,
  output logic                            flush_tlb_gvma_o,
  output logic                            flush_dcache_o,
  fence_link_if.decoder_mp                link
);

  logic fence_active_d, fence_active_q;
  // Unregistered data-cache flush request
  logic flush_dcache;
  logic dcache_done;

  // Requests gated by the fixed feature set
  logic sfence_req, hfence_vvma_req, hfence_gvma_req, commit_req;
  logic debug_req, pc_flush_req, trap_req;

  assign sfence_req      = flush_pkg::HasSupervisor & sfence_vma_i;
  assign hfence_vvma_req = flush_pkg::HasHypervisor & hfence_vvma_i;
  assign hfence_gvma_req = flush_pkg::HasHypervisor & hfence_gvma_i;
  assign commit_req      = flush_pkg::HasAtomics & flush_commit_i;
  assign debug_req       = flush_pkg::HasDebug & set_debug_pc_i;

  // Anything behaving like a CSR write with side effects
  assign pc_flush_req = fence_i | fence_i_i | sfence_req | hfence_vvma_req
                      | hfence_gvma_req | flush_csr_i | flush_acc_i | commit_req;
  assign trap_req     = ex_valid_i | eret_i | debug_req;

  // Pending fence flush acknowledged this cycle
  assign dcache_done = fence_active_q & flush_dcache_ack_i;

  // ----------------------------------------
  // Request rules where later ones override
  // ----------------------------------------
  always_comb begin
    fence_active_d         = fence_active_q;
    flush_dcache           = 1'b0;
    set_pc_commit_o        = 1'b0;
    flush_if_o             = 1'b0;
    flush_unissued_instr_o = 1'b0;
    flush_id_o             = 1'b0;
    flush_ex_o             = 1'b0;
    flush_bp_o             = 1'b0;
    flush_icache_o         = 1'b0;
    flush_tlb_o            = 1'b0;
    flush_tlb_vvma_o       = 1'b0;
    flush_tlb_gvma_o       = 1'b0;

    // Mispredict only kills the front end
    if (mispredict_i) begin
      flush_unissued_instr_o = 1'b1;
      flush_if_o             = 1'b1;
    end

    // Restart from the commit PC with an empty pipeline
    if (pc_flush_req) begin
      set_pc_commit_o        = 1'b1;
      flush_if_o             = 1'b1;
      flush_unissued_instr_o = 1'b1;
      flush_id_o             = 1'b1;
      flush_ex_o             = 1'b1;
    end

    if (fence_i_i) flush_icache_o = 1'b1;

    // Write-back cache must be written out on fence and fence.i
    if (flush_pkg::DcacheWriteBack && (fence_i || fence_i_i)) begin
      flush_dcache   = 1'b1;
      fence_active_d = 1'b1;
    end

    // Hold the flush until the cache acknowledges
    if (dcache_done) begin
      fence_active_d = 1'b0;
    end else if (fence_active_q) begin
      flush_dcache = 1'b1;
    end

    // Guest translations when virtualised
    if (sfence_req) begin
      if (flush_pkg::HasHypervisor && v_i) flush_tlb_vvma_o = 1'b1;
      else flush_tlb_o = 1'b1;
    end
    if (hfence_vvma_req) flush_tlb_vvma_o = 1'b1;
    if (hfence_gvma_req) flush_tlb_gvma_o = 1'b1;

    // Fence.t hands over to the sequencer
    if (fence_t_i) begin
      flush_icache_o = 1'b1;
      flush_dcache   = 1'b1;
    end

    // Trap target comes from the CSR file, not the commit PC
    if (trap_req) begin
      set_pc_commit_o        = 1'b0;
      flush_if_o             = 1'b1;
      flush_unissued_instr_o = 1'b1;
      flush_id_o             = 1'b1;
      flush_ex_o             = 1'b1;
      flush_bp_o             = 1'b1;
    end
  end

  // Link to the sequencer
  assign link.fence_t_start = fence_t_i;
  assign link.resume_pc     = pc_commit_i + flush_pkg::AddrWidth'(flush_pkg::InstrBytes);
  assign link.fence_active  = fence_active_q;
  assign link.dcache_done   = dcache_done;

  // ----------------------------------------
  // Registers
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fence_active_q <= 1'b0;
      flush_dcache_o <= 1'b0;
    end else begin
      fence_active_q <= fence_active_d;
      // Registered to relieve the cache path
      flush_dcache_o <= flush_dcache;
    end
  end

  // An ack only ends a fence flush that is still driven to the cache
  a_done_ends_fence : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    link.dcache_done |-> flush_dcache_o
  );

endmodule

// File: logic/fence_t_sequencer.sv
`timescale 1ns/10ps

module fence_t_sequencer (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic [flush_pkg::AddrWidth-1:0] boot_addr_i,
  input  logic                            cache_busy_i,
  input  logic                            flush_dcache_ack_i,
  input  logic                            halt_csr_i,
  input  logic                            halt_acc_i,
  input  logic                            time_irq_i,
  input  logic                            fence_t_src_sel_i,
  input  flush_pkg::priv_lvl_e            priv_lvl_i,
  input  logic [flush_pkg::PadWidth-1:0]  fence_t_pad_i,
  fence_link_if.sequencer_mp              link,
  output logic                            halt_o,
  output logic                            stall_cache_o,
  output logic                            cache_init_no,
  output logic                            rst_uarch_no,
  output logic [flush_pkg::AddrWidth-1:0] rst_addr_o,
  output logic [flush_pkg::PadWidth-1:0]  pad_elapsed_o
);

  flush_pkg::fence_t_state_e state_d, state_q;

  logic [flush_pkg::DrainCntW-1:0] drain_cnt_q;
  logic [flush_pkg::PadWidth-1:0]  pad_cnt_q;
  logic [flush_pkg::RstCntW-1:0]   rst_cnt_d, rst_cnt_q;
  logic [flush_pkg::CacheInitHold-1:0] cache_init_q;
  logic [flush_pkg::AddrWidth-1:0] rst_addr_q;

  // Edge detection for the pad start event
  logic                 time_irq_q;
  flush_pkg::priv_lvl_e priv_lvl_q;
  logic                 load_pad;
  logic                 drain_full;
  logic                 in_rst;

  // Timer interrupt edge or exit from user mode
  assign load_pad = fence_t_src_sel_i
                  ? (priv_lvl_q == flush_pkg::PRIV_LVL_U) && (priv_lvl_i != flush_pkg::PRIV_LVL_U)
                  : time_irq_i & ~time_irq_q;

  assign drain_full = (drain_cnt_q == flush_pkg::DrainCntW'(flush_pkg::DrainCycles));

  // ----------------------------------------
  // Fence.t FSM
  // ----------------------------------------
  always_comb begin
    state_d       = state_q;
    rst_cnt_d     = rst_cnt_q;
    rst_uarch_no  = 1'b1;
    in_rst        = 1'b0;
    pad_elapsed_o = '0;

    unique case (state_q)
      flush_pkg::FT_IDLE: begin
        if (link.fence_t_start) state_d = flush_pkg::FT_FLUSH_DCACHE;
      end

      // Cache writes back everything first
      flush_pkg::FT_FLUSH_DCACHE: begin
        if (flush_dcache_ack_i) state_d = flush_pkg::FT_DRAIN;
      end

      // Wait for the cache to go quiet
      flush_pkg::FT_DRAIN: begin
        if (drain_full) begin
          state_d = flush_pkg::FT_PAD;
          // Pad time already consumed when padding begins
          if (pad_cnt_q != '0) pad_elapsed_o = fence_t_pad_i - pad_cnt_q;
        end
      end

      flush_pkg::FT_PAD: begin
        if (pad_cnt_q == '0) state_d = flush_pkg::FT_RST_UARCH;
      end

      // Micro-reset for a fixed number of cycles
      flush_pkg::FT_RST_UARCH: begin
        rst_uarch_no = 1'b0;
        in_rst       = 1'b1;
        if (rst_cnt_q == flush_pkg::RstCntW'(flush_pkg::UarchRstCycles - 1)) begin
          rst_cnt_d = '0;
          state_d   = flush_pkg::FT_IDLE;
        end else begin
          rst_cnt_d = rst_cnt_q + 1'b1;
        end
      end

      default: state_d = flush_pkg::FT_IDLE;
    endcase
  end

  // No new cache requests during the whole sequence
  assign stall_cache_o = (state_q != flush_pkg::FT_IDLE);
  assign halt_o        = halt_csr_i | halt_acc_i | link.fence_active | stall_cache_o;
  // Caches skip init during reset and a short tail
  assign cache_init_no = |cache_init_q;
  assign rst_addr_o    = rst_addr_q;

  // ----------------------------------------
  // Registers
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= flush_pkg::FT_IDLE;
      rst_cnt_q    <= '0;
      cache_init_q <= '0;
      time_irq_q   <= 1'b0;
      priv_lvl_q   <= flush_pkg::PRIV_LVL_M;
      rst_addr_q   <= boot_addr_i;
    end else begin
      state_q      <= state_d;
      rst_cnt_q    <= rst_cnt_d;
      cache_init_q <= {cache_init_q[flush_pkg::CacheInitHold-2:0], in_rst};
      time_irq_q   <= time_irq_i;
      priv_lvl_q   <= priv_lvl_i;
      // Where fetch resumes after the micro-reset
      if (link.fence_t_start) rst_addr_q <= link.resume_pc;
    end
  end

  // Drain counter restarts whenever the cache is busy
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      drain_cnt_q <= '0;
    end else if (cache_busy_i) begin
      drain_cnt_q <= '0;
    end else if (!drain_full) begin
      drain_cnt_q <= drain_cnt_q + 1'b1;
    end
  end

  // Pad counter, loaded in any state, runs down to zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pad_cnt_q <= '0;
    end else if (load_pad) begin
      pad_cnt_q <= fence_t_pad_i;
    end else if (pad_cnt_q != '0) begin
      pad_cnt_q <= pad_cnt_q - 1'b1;
    end
  end

  // Micro-reset is one unbroken window of fixed length
  a_rst_window : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $fell(rst_uarch_no) |->
      (!rst_uarch_no) [*flush_pkg::UarchRstCycles]
      ##1 rst_uarch_no
  );

  // Decoder only starts fence.t while the sequencer is free
  a_start_in_idle : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    link.fence_t_start |-> state_q == flush_pkg::FT_IDLE
  );

endmodule

// File: logic/flush_ctrl_top.sv
`timescale 1ns/10ps

module flush_ctrl_top (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  // Flush requests
  input  logic                            v_i,
  input  logic                            mispredict_i,
  input  logic                            fence_i,
  input  logic                            fence_i_i,
  input  logic                            fence_t_i,
  input  logic                            sfence_vma_i,
  input  logic                            hfence_vvma_i,
  input  logic                            hfence_gvma_i,
  input  logic                            flush_csr_i,
  input  logic                            flush_acc_i,
  input  logic                            flush_commit_i,
  input  logic                            ex_valid_i,
  input  logic                            eret_i,
  input  logic                            set_debug_pc_i,
  input  logic                            flush_dcache_ack_i,
  input  logic [flush_pkg::AddrWidth-1:0] pc_commit_i,
  // Stage and cache flushes
  output logic                            set_pc_commit_o,
  output logic                            flush_if_o,
  output logic                            flush_unissued_instr_o,
  output logic                            flush_id_o,
  output logic                            flush_ex_o,
  output logic                            flush_bp_o,
  output logic                            flush_icache_o,
  output logic                            flush_tlb_o,
  output logic                            flush_tlb_vvma_o,
  output logic                            flush_tlb_gvma_o,
  output logic                            flush_dcache_o,
  // Fence.t side
  input  logic [flush_pkg::AddrWidth-1:0] boot_addr_i,
  input  logic                            cache_busy_i,
  input  logic                            halt_csr_i,
  input  logic                            halt_acc_i,
  input  logic                            time_irq_i,
  input  logic                            fence_t_src_sel_i,
  input  flush_pkg::priv_lvl_e            priv_lvl_i,
  input  logic [flush_pkg::PadWidth-1:0]  fence_t_pad_i,
  output logic                            halt_o,
  output logic                            stall_cache_o,
  output logic                            cache_init_no,
  output logic                            rst_uarch_no,
  output logic [flush_pkg::AddrWidth-1:0] rst_addr_o,
  output logic [flush_pkg::PadWidth-1:0]  pad_elapsed_o
);

  fence_link_if link ();

  flush_decoder u_decoder (
    .clk_i,
    .rst_ni,
    .v_i,
    .mispredict_i,
    .fence_i,
    .fence_i_i,
    .fence_t_i,
    .sfence_vma_i,
    .hfence_vvma_i,
    .hfence_gvma_i,
    .flush_csr_i,
    .flush_acc_i,
    .flush_commit_i,
    .ex_valid_i,
    .eret_i,
    .set_debug_pc_i,
    .flush_dcache_ack_i,
    .pc_commit_i,
    .set_pc_commit_o,
    .flush_if_o,
    .flush_unissued_instr_o,
    .flush_id_o,
    .flush_ex_o,
    .flush_bp_o,
    .flush_icache_o,
    .flush_tlb_o,
    .flush_tlb_vvma_o,
    .flush_tlb_gvma_o,
    .flush_dcache_o,
    .link (link.decoder_mp)
  );

  // Sequencer sees the same ack as the decoder
  fence_t_sequencer u_sequencer (
    .clk_i,
    .rst_ni,
    .boot_addr_i,
    .cache_busy_i,
    .flush_dcache_ack_i,
    .halt_csr_i,
    .halt_acc_i,
    .time_irq_i,
    .fence_t_src_sel_i,
    .priv_lvl_i,
    .fence_t_pad_i,
    .link (link.sequencer_mp),
    .halt_o,
    .stall_cache_o,
    .cache_init_no,
    .rst_uarch_no,
    .rst_addr_o,
    .pad_elapsed_o
  );

endmodule

// File: test/flush_ctrl_tb.sv
`timescale 1ns/10ps

module flush_ctrl_tb;

  // Wait limits in cycles
  localparam int unsigned IdleTimeout = 2000;
  localparam int unsigned AckTimeout  = 200;
  localparam int unsigned SeqTimeout  = 4000;
  localparam int unsigned RstTimeout  = 64;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic v_i, mispredict_i, fence_i, fence_i_i, fence_t_i, sfence_vma_i;
  logic hfence_vvma_i, hfence_gvma_i, flush_csr_i, flush_acc_i, flush_commit_i;
  logic ex_valid_i, eret_i, set_debug_pc_i, flush_dcache_ack_i;
  logic [31:0] pc_commit_i, boot_addr_i, fence_t_pad_i;
  logic cache_busy_i, halt_csr_i, halt_acc_i, time_irq_i, fence_t_src_sel_i;
  flush_pkg::priv_lvl_e priv_lvl_i;
  logic set_pc_commit_o, flush_if_o, flush_unissued_instr_o, flush_id_o, flush_ex_o;
  logic flush_bp_o, flush_icache_o, flush_tlb_o, flush_tlb_vvma_o, flush_tlb_gvma_o;
  logic flush_dcache_o, halt_o, stall_cache_o, cache_init_no, rst_uarch_no;
  logic [31:0] rst_addr_o, pad_elapsed_o;

  // Reference model state
  flush_pkg::fence_t_state_e m_state;
  flush_pkg::priv_lvl_e m_priv_q;
  logic m_fa, m_fd, m_irq_q;
  logic [2:0] m_init;
  logic [31:0] m_pad, m_rst_addr;
  int unsigned m_drain, m_rst_cnt;

  int unsigned value_errors, other_errors;

  always #4 clk_i = ~clk_i;

  flush_ctrl_top DUT (.*);

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("Error %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("Error %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic report_timeout(input string what);
    other_errors++;
    $display("Timeout: %s at %0t", what, $time);
  endtask

  // Expected outputs from the request rules and the model registers
  task automatic check_outputs();
    logic pc_req;
    logic trap;
    logic [31:0] exp_pad;
    pc_req = fence_i | fence_i_i | sfence_vma_i | hfence_vvma_i | hfence_gvma_i
           | flush_csr_i | flush_acc_i | flush_commit_i;
    trap = ex_valid_i | eret_i | set_debug_pc_i;
    exp_pad = '0;
    // Elapsed pad only on the drain to pad step
    if (m_state == flush_pkg::FT_DRAIN && m_drain == flush_pkg::DrainCycles && m_pad != 0)
      exp_pad = fence_t_pad_i - m_pad;
    compare_bit("set_pc_commit_o", set_pc_commit_o, pc_req & ~trap);
    compare_bit("flush_if_o", flush_if_o, mispredict_i | pc_req | trap);
    compare_bit("flush_unissued_instr_o", flush_unissued_instr_o, mispredict_i | pc_req | trap);
    compare_bit("flush_id_o", flush_id_o, pc_req | trap);
    compare_bit("flush_ex_o", flush_ex_o, pc_req | trap);
    compare_bit("flush_bp_o", flush_bp_o, trap);
    compare_bit("flush_icache_o", flush_icache_o, fence_i_i | fence_t_i);
    compare_bit("flush_tlb_o", flush_tlb_o, sfence_vma_i & ~v_i);
    compare_bit("flush_tlb_vvma_o", flush_tlb_vvma_o, (sfence_vma_i & v_i) | hfence_vvma_i);
    compare_bit("flush_tlb_gvma_o", flush_tlb_gvma_o, hfence_gvma_i);
    compare_bit("flush_dcache_o", flush_dcache_o, m_fd);
    compare_bit("stall_cache_o", stall_cache_o, m_state != flush_pkg::FT_IDLE);
    compare_bit("halt_o", halt_o,
                halt_csr_i | halt_acc_i | m_fa | (m_state != flush_pkg::FT_IDLE));
    compare_bit("rst_uarch_no", rst_uarch_no, m_state != flush_pkg::FT_RST_UARCH);
    compare_bit("cache_init_no", cache_init_no, |m_init);
    compare_word("rst_addr_o", rst_addr_o, m_rst_addr);
    compare_word("pad_elapsed_o", pad_elapsed_o, exp_pad);
  endtask

  // ----------------------------------------
  // Model
  // ----------------------------------------
  task automatic reset_model();
    m_state    = flush_pkg::FT_IDLE;
    m_priv_q   = flush_pkg::PRIV_LVL_M;
    m_fa       = 1'b0;
    m_fd       = 1'b0;
    m_irq_q    = 1'b0;
    m_init     = '0;
    m_pad      = '0;
    m_drain    = 0;
    m_rst_cnt  = 0;
    m_rst_addr = boot_addr_i;
  endtask

  // One clock edge of the model, from the inputs held at that edge
  task automatic advance_model();
    logic load;
    flush_pkg::fence_t_state_e nstate;
    load = fence_t_src_sel_i
         ? (m_priv_q == flush_pkg::PRIV_LVL_U && priv_lvl_i != flush_pkg::PRIV_LVL_U)
         : (time_irq_i && !m_irq_q);
    nstate = m_state;
    case (m_state)
      flush_pkg::FT_IDLE:         if (fence_t_i) nstate = flush_pkg::FT_FLUSH_DCACHE;
      flush_pkg::FT_FLUSH_DCACHE: if (flush_dcache_ack_i) nstate = flush_pkg::FT_DRAIN;
      flush_pkg::FT_DRAIN:
        if (m_drain == flush_pkg::DrainCycles) nstate = flush_pkg::FT_PAD;
      flush_pkg::FT_PAD:          if (m_pad == 0) nstate = flush_pkg::FT_RST_UARCH;
      flush_pkg::FT_RST_UARCH:
        if (m_rst_cnt == flush_pkg::UarchRstCycles - 1) nstate = flush_pkg::FT_IDLE;
      default:                    nstate = flush_pkg::FT_IDLE;
    endcase
    // Counts micro-reset cycles already spent
    if (m_state == flush_pkg::FT_RST_UARCH && nstate == flush_pkg::FT_RST_UARCH)
      m_rst_cnt = m_rst_cnt + 1;
    else
      m_rst_cnt = 0;
    m_init = {m_init[1:0], m_state == flush_pkg::FT_RST_UARCH};
    // Flush request uses the old pending flag
    m_fd = fence_i | fence_i_i | fence_t_i | (m_fa & ~flush_dcache_ack_i);
    m_fa = m_fa ? ~flush_dcache_ack_i : (fence_i | fence_i_i);
    if (cache_busy_i) m_drain = 0;
    else if (m_drain < flush_pkg::DrainCycles) m_drain = m_drain + 1;
    if (load) m_pad = fence_t_pad_i;
    else if (m_pad != 0) m_pad = m_pad - 1;
    m_irq_q  = time_irq_i;
    m_priv_q = priv_lvl_i;
    if (fence_t_i) m_rst_addr = pc_commit_i + 32'(flush_pkg::InstrBytes);
    m_state = nstate;
  endtask

  // Check mid-cycle, step the model on the edge, then leave 1 ns for driving
  task automatic tick();
    @(negedge clk_i);
    check_outputs();
    @(posedge clk_i);
    advance_model();
    #1;
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  task automatic drive_inputs(input bit allow_fence);
    bit quiet;
    // Fences only start with the sequencer idle and no flush pending
    quiet = allow_fence && (m_state == flush_pkg::FT_IDLE) && !m_fa;
    v_i            = (($urandom % 2) == 0);
    mispredict_i   = (($urandom % 6) == 0);
    fence_i        = quiet && (($urandom % 24) == 0);
    fence_i_i      = quiet && (($urandom % 24) == 0);
    fence_t_i      = quiet && (($urandom % 48) == 0);
    sfence_vma_i   = (($urandom % 10) == 0);
    hfence_vvma_i  = (($urandom % 10) == 0);
    hfence_gvma_i  = (($urandom % 10) == 0);
    flush_csr_i    = (($urandom % 10) == 0);
    flush_acc_i    = (($urandom % 10) == 0);
    flush_commit_i = (($urandom % 10) == 0);
    ex_valid_i     = (($urandom % 12) == 0);
    eret_i         = (($urandom % 16) == 0);
    set_debug_pc_i = (($urandom % 24) == 0);
    pc_commit_i    = $urandom & 32'hffff_fffc;
    halt_csr_i     = (($urandom % 8) == 0);
    halt_acc_i     = (($urandom % 8) == 0);
    cache_busy_i   = (($urandom % 16) == 0);
    if (($urandom % 16) == 0) time_irq_i = ~time_irq_i;
    if (($urandom % 16) == 0) begin
      case ($urandom % 3)
        0:       priv_lvl_i = flush_pkg::PRIV_LVL_U;
        1:       priv_lvl_i = flush_pkg::PRIV_LVL_S;
        default: priv_lvl_i = flush_pkg::PRIV_LVL_M;
      endcase
    end
    if (($urandom % 32) == 0) fence_t_pad_i = $urandom % 16;
    if (($urandom % 32) == 0) fence_t_src_sel_i = (($urandom % 2) == 1);
    // Cache acks after a random delay once a flush is outstanding
    flush_dcache_ack_i = (m_fa || m_fd || m_state == flush_pkg::FT_FLUSH_DCACHE)
                       && (($urandom % 6) == 0);
  endtask

  task automatic wait_quiet();
    int unsigned cnt;
    cnt = 0;
    while (((m_state != flush_pkg::FT_IDLE) || m_fa) && (cnt < IdleTimeout)) begin
      drive_inputs(1'b0);
      tick();
      cnt++;
    end
    if ((m_state != flush_pkg::FT_IDLE) || m_fa) report_timeout("controller never went idle");
  endtask

  // Fence or fence.i with the flush held until the cycle after the ack
  task automatic run_fence();
    int unsigned cnt;
    wait_quiet();
    drive_inputs(1'b0);
    if (($urandom % 2) == 0) fence_i = 1'b1;
    else fence_i_i = 1'b1;
    tick();
    cnt = 0;
    while (flush_dcache_o && (cnt < AckTimeout)) begin
      if (!halt_o) begin
        other_errors++;
        $display("halt_o dropped while a data-cache flush was pending at %0t", $time);
      end
      drive_inputs(1'b0);
      tick();
      cnt++;
    end
    if (flush_dcache_o) report_timeout("flush_dcache_o never dropped after fence");
  endtask

  // Full fence.t sequence up to the end of the micro-reset
  task automatic run_fence_t();
    logic [31:0] pc;
    int unsigned cnt;
    int unsigned low_cnt;
    wait_quiet();
    drive_inputs(1'b0);
    fence_t_i = 1'b1;
    pc = pc_commit_i;
    tick();
    cnt = 0;
    while (rst_uarch_no && (cnt < SeqTimeout)) begin
      if (!stall_cache_o || !halt_o) begin
        other_errors++;
        $display("stall_cache_o or halt_o low during fence.t at %0t", $time);
      end
      drive_inputs(1'b0);
      tick();
      cnt++;
    end
    if (rst_uarch_no) begin
      report_timeout("micro-reset never started after fence.t");
      return;
    end
    low_cnt = 0;
    while (!rst_uarch_no && (low_cnt < RstTimeout)) begin
      if (!stall_cache_o || !halt_o) begin
        other_errors++;
        $display("stall_cache_o or halt_o low during micro-reset at %0t", $time);
      end
      drive_inputs(1'b0);
      tick();
      low_cnt++;
    end
    if (low_cnt != flush_pkg::UarchRstCycles) begin
      other_errors++;
      $display("rst_uarch_no was low for %0d cycles instead of %0d",
               low_cnt, flush_pkg::UarchRstCycles);
    end
    compare_word("rst_addr_o", rst_addr_o, pc + 32'(flush_pkg::InstrBytes));
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    int unsigned i;
    void'($urandom(84));
    value_errors = 0;
    other_errors = 0;
    rst_ni = 1'b0;
    {v_i, mispredict_i, fence_i, fence_i_i, fence_t_i, sfence_vma_i} = '0;
    {hfence_vvma_i, hfence_gvma_i, flush_csr_i, flush_acc_i, flush_commit_i} = '0;
    {ex_valid_i, eret_i, set_debug_pc_i, flush_dcache_ack_i} = '0;
    {cache_busy_i, halt_csr_i, halt_acc_i, time_irq_i, fence_t_src_sel_i} = '0;
    priv_lvl_i    = flush_pkg::PRIV_LVL_M;
    fence_t_pad_i = 32'd5;
    pc_commit_i   = '0;
    boot_addr_i   = $urandom & 32'hffff_fffc;
    reset_model();
    repeat (15) @(posedge clk_i);
    // Reset values
    @(negedge clk_i);
    compare_bit("rst_uarch_no", rst_uarch_no, 1'b1);
    compare_bit("flush_dcache_o", flush_dcache_o, 1'b0);
    compare_bit("stall_cache_o", stall_cache_o, 1'b0);
    compare_bit("cache_init_no", cache_init_no, 1'b0);
    compare_word("rst_addr_o", rst_addr_o, boot_addr_i);
    @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    // Mixed random traffic
    for (i = 0; i < 3000; i++) begin
      drive_inputs(1'b1);
      tick();
    end
    for (i = 0; i < 10; i++) run_fence();
    for (i = 0; i < 12; i++) run_fence_t();
    for (i = 0; i < 500; i++) begin
      drive_inputs(1'b1);
      tick();
    end
    $display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: flush_ctrl.f
logic/flush_pkg.sv
logic/fence_link_if.sv
logic/flush_decoder.sv
logic/fence_t_sequencer.sv
logic/flush_ctrl_top.sv
test/flush_ctrl_tb.sv

// File: Makefile
# Verilator build and run for the flush controller testbench

VERILATOR ?= verilator
TOP       ?= flush_ctrl_tb
FILELIST  ?= flush_ctrl.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= all tests passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	cat $(LOG)
	@$(MAKE) --no-print-directory check

check:
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "FAIL: pass message not in $(LOG)"; exit 1; }
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
